//--- hdl/pc_io_defs.svh
// I/O subsystem address map
`ifndef PC_IO_DEFS_SVH
`define PC_IO_DEFS_SVH

// LED register, decoded on address bits 15 to 8 only
`define IO_PORT_LED 16'hF100

// Switch input port, read only
`define IO_PORT_SW 16'h0102

// Interval timer reload register
`define IO_PORT_TIMER 16'h0040

// Interrupt mask register
`define IO_PORT_IRQ_MASK 16'h0020

// Word RAM depth as address bits, 1024 words
`define RAM_ADDR_BITS 10

// Zero keeps the timer stopped
`define TIMER_RELOAD_DEFAULT 16'd0

`endif

//--- hdl/pc_io_pkg.sv
// I/O subsystem types
package pc_io_pkg;

  // Bus data word
  typedef logic [15:0] word_t;

  // Word address, byte address bit 0 is implied by the selects
  typedef logic [19:1] addr_t;

  // Byte lane selects
  typedef logic [1:0] sel_t;

  // Interrupt request lines, line 0 is the timer
  typedef logic [7:0] irq_vec_t;

  // Interrupt number
  typedef logic [2:0] iid_t;

  // Interrupt controller acknowledge FSM
  typedef enum logic [1:0] {
    IRQ_IDLE    = 2'd0,
    IRQ_REQUEST = 2'd1,
    IRQ_SERVE   = 2'd2
  } irq_state_t;

endpackage

//--- hdl/io_decoder.sv
// System bus address decoder
`timescale 1ns/1ns
`include "pc_io_defs.svh"

module io_decoder
  import pc_io_pkg::*;
(
  input  logic  clk,
  input  logic  reset_i,
  input  addr_t adr_i,
  input  word_t dat_i,
  input  logic  we_i,
  input  logic  tga_i,
  input  sel_t  sel_i,
  input  logic  stb_i,
  input  logic  cyc_i,
  input  logic  inta_i,
  input  word_t sw_i,
  input  word_t ram_dat_i,
  input  logic  ram_ack_i,
  input  word_t timer_dat_i,
  input  word_t mask_dat_i,
  input  iid_t  iid_i,
  output logic  ram_stb_o,
  output logic  timer_we_o,
  output logic  mask_we_o,
  output word_t dat_o,
  output logic  ack_o,
  output word_t led_o
);

  localparam word_t LED_PORT   = `IO_PORT_LED;
  localparam word_t SW_PORT    = `IO_PORT_SW;
  localparam word_t TIMER_PORT = `IO_PORT_TIMER;
  localparam word_t MASK_PORT  = `IO_PORT_IRQ_MASK;

  logic  bus_cyc;
  logic  io_cyc;
  logic  io_wr;
  logic  led_arena;
  logic  sw_arena;
  logic  timer_arena;
  logic  mask_arena;
  word_t io_dat;

  assign bus_cyc = stb_i & cyc_i;
  assign io_cyc  = bus_cyc & tga_i;

  // A write with no byte lane selected is dropped
  assign io_wr = io_cyc & we_i & (|sel_i);

  // I/O arenas
  assign led_arena   = (adr_i[15:8] == LED_PORT[15:8]);
  assign sw_arena    = (adr_i[15:1] == SW_PORT[15:1]);
  assign timer_arena = (adr_i[15:1] == TIMER_PORT[15:1]);
  assign mask_arena  = (adr_i[15:1] == MASK_PORT[15:1]);

  // All of memory space belongs to the RAM
  assign ram_stb_o  = bus_cyc & ~tga_i;
  assign timer_we_o = io_wr & timer_arena;
  assign mask_we_o  = io_wr & mask_arena;

  // I/O ports answer at once, memory waits for the RAM
  assign ack_o = tga_i ? bus_cyc : ram_ack_i;

  always_comb begin
    if (sw_arena && !we_i) begin
      io_dat = sw_i;
    end else if (timer_arena) begin
      io_dat = timer_dat_i;
    end else if (mask_arena) begin
      io_dat = mask_dat_i;
    end else begin
      // LED port is write only and reads as unused
      io_dat = 16'hFFFF;
    end
  end

  // Interrupt vector word wins over any slave data
  always_comb begin
    if (inta_i) begin
      dat_o = {13'b0_0000_0000_0001, iid_i};
    end else if (tga_i) begin
      dat_o = io_dat;
    end else begin
      dat_o = ram_dat_i;
    end
  end

  // LED output register
  always_ff @(posedge clk) begin
    if (reset_i) begin
      led_o <= '0;
    end else if (io_wr && led_arena) begin
      led_o <= dat_i;
    end
  end

endmodule

//--- hdl/word_ram.sv
// Word-wide memory slave
`timescale 1ns/1ns
`include "pc_io_defs.svh"

module word_ram
  import pc_io_pkg::*;
#(
  parameter int ADDR_BITS = `RAM_ADDR_BITS
) (
  input  logic  clk,
  input  logic  reset_i,
  input  addr_t adr_i,
  input  word_t dat_i,
  input  logic  we_i,
  input  logic  stb_i,
  output word_t dat_o,
  output logic  ack_o
);

  localparam int DEPTH = 2 ** ADDR_BITS;

  word_t                mem [DEPTH];
  logic [ADDR_BITS-1:0] ram_idx;

  // Upper address bits ignored, so the array aliases
  assign ram_idx = adr_i[ADDR_BITS:1];

  // Write once per cycle, read data lands with the acknowledge
  always_ff @(posedge clk) begin
    if (stb_i && we_i && !ack_o) begin
      mem[ram_idx] <= dat_i;
    end
    dat_o <= mem[ram_idx];
  end

  // One wait state, then a single-cycle acknowledge
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= stb_i & ~ack_o;
    end
  end

endmodule

//--- hdl/interval_timer.sv
// Programmable interval timer
`timescale 1ns/1ns
`include "pc_io_defs.svh"

module interval_timer
  import pc_io_pkg::*;
(
  input  logic  clk,
  input  logic  reset_i,
  input  logic  we_i,
  input  word_t dat_i,
  output word_t reload_o,
  output logic  tick_o
);

  word_t count;
  logic  running;

  // Zero reload parks the counter
  assign running = (reload_o != '0);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      reload_o <= `TIMER_RELOAD_DEFAULT;
      count    <= `TIMER_RELOAD_DEFAULT;
      tick_o   <= 1'b0;
    end else if (we_i) begin
      // New period starts from the write
      reload_o <= dat_i;
      count    <= dat_i;
      tick_o   <= 1'b0;
    end else begin
      tick_o <= running && (count == 16'd1);
      if (running) begin
        if (count == 16'd1) begin
          count <= reload_o;
        end else begin
          count <= count - 16'd1;
        end
      end
    end
  end

endmodule

//--- hdl/irq_controller.sv
// Priority interrupt controller
`timescale 1ns/1ns

module irq_controller
  import pc_io_pkg::*;
(
  input  logic     clk,
  input  logic     reset_i,
  input  irq_vec_t irq_i,
  input  logic     mask_we_i,
  input  word_t    dat_i,
  input  logic     inta_i,
  output word_t    mask_o,
  output logic     intr_o,
  output iid_t     iid_o
);

  irq_state_t state;
  irq_state_t state_next;
  irq_vec_t   irq_q;
  irq_vec_t   pending;
  irq_vec_t   active;
  irq_vec_t   clear;
  iid_t       prio_iid;
  iid_t       iid_q;
  logic       any_active;
  logic       take;

  // Mask bit set means the line is blocked
  assign active     = pending & ~mask_o[7:0];
  assign any_active = |active;

  // Lowest-numbered line has the highest priority
  always_comb begin
    prio_iid = '0;
    for (int i = 7; i >= 0; i--) begin
      if (active[i]) begin
        prio_iid = iid_t'(i);
      end
    end
  end

  // First cycle of the acknowledge takes the winner
  assign take  = (state == IRQ_REQUEST) && inta_i && any_active;
  assign clear = take ? (irq_vec_t'(1) << prio_iid) : '0;

  always_comb begin
    state_next = state;
    case (state)
      IRQ_IDLE: begin
        if (any_active) begin
          state_next = IRQ_REQUEST;
        end
      end
      IRQ_REQUEST: begin
        if (!any_active) begin
          state_next = IRQ_IDLE;
        end else if (inta_i) begin
          state_next = IRQ_SERVE;
        end
      end
      IRQ_SERVE: begin
        if (!inta_i) begin
          state_next = IRQ_IDLE;
        end
      end
      default: state_next = IRQ_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state   <= IRQ_IDLE;
      irq_q   <= '0;
      pending <= '0;
      mask_o  <= '0;
    end else begin
      state <= state_next;
      irq_q <= irq_i;
      // New edge beats a clear in the same cycle
      pending <= (pending & ~clear) | (irq_i & ~irq_q);
      if (mask_we_i) begin
        mask_o <= dat_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      iid_q <= prio_iid;
    end
  end

  assign intr_o = (state == IRQ_REQUEST);

  // Live winner during the request, held number while served
  assign iid_o = (state == IRQ_SERVE) ? iid_q : prio_iid;

endmodule

//--- hdl/io_system.sv
// PC I/O subsystem top
`timescale 1ns/1ns
`include "pc_io_defs.svh"

module io_system
  import pc_io_pkg::*;
(
  input  logic       clk,
  input  logic       reset_i,
  input  addr_t      adr_i,
  input  word_t      dat_i,
  input  logic       we_i,
  input  logic       tga_i,
  input  sel_t       sel_i,
  input  logic       stb_i,
  input  logic       cyc_i,
  input  logic       inta_i,
  input  word_t      sw_i,
  input  logic [7:1] irq_i,
  output word_t      dat_o,
  output logic       ack_o,
  output logic       intr_o,
  output word_t      led_o
);

  logic     ram_stb;
  logic     ram_ack;
  word_t    ram_dat;
  logic     timer_we;
  word_t    timer_reload;
  logic     timer_tick;
  logic     mask_we;
  word_t    mask_dat;
  iid_t     iid;
  irq_vec_t irq_lines;

  // Timer owns line 0
  assign irq_lines = {irq_i, timer_tick};

  io_decoder io_decoder_inst (
    .clk         (clk),
    .reset_i     (reset_i),
    .adr_i       (adr_i),
    .dat_i       (dat_i),
    .we_i        (we_i),
    .tga_i       (tga_i),
    .sel_i       (sel_i),
    .stb_i       (stb_i),
    .cyc_i       (cyc_i),
    .inta_i      (inta_i),
    .sw_i        (sw_i),
    .ram_dat_i   (ram_dat),
    .ram_ack_i   (ram_ack),
    .timer_dat_i (timer_reload),
    .mask_dat_i  (mask_dat),
    .iid_i       (iid),
    .ram_stb_o   (ram_stb),
    .timer_we_o  (timer_we),
    .mask_we_o   (mask_we),
    .dat_o       (dat_o),
    .ack_o       (ack_o),
    .led_o       (led_o)
  );

  word_ram #(
    .ADDR_BITS (`RAM_ADDR_BITS)
  ) word_ram_inst (
    .clk     (clk),
    .reset_i (reset_i),
    .adr_i   (adr_i),
    .dat_i   (dat_i),
    .we_i    (we_i),
    .stb_i   (ram_stb),
    .dat_o   (ram_dat),
    .ack_o   (ram_ack)
  );

  interval_timer interval_timer_inst (
    .clk      (clk),
    .reset_i  (reset_i),
    .we_i     (timer_we),
    .dat_i    (dat_i),
    .reload_o (timer_reload),
    .tick_o   (timer_tick)
  );

  irq_controller irq_controller_inst (
    .clk       (clk),
    .reset_i   (reset_i),
    .irq_i     (irq_lines),
    .mask_we_i (mask_we),
    .dat_i     (dat_i),
    .inta_i    (inta_i),
    .mask_o    (mask_dat),
    .intr_o    (intr_o),
    .iid_o     (iid)
  );

endmodule

//--- test/io_system_properties.sv
// Bus and interrupt protocol assertions
`timescale 1ns/1ns

module io_system_properties
  import pc_io_pkg::*;
(
  input logic       clk,
  input logic       reset_i,
  input logic       stb_i,
  input logic       ack_i,
  input logic       intr_i,
  input irq_state_t state_i
);

  // Acknowledge only answers a live strobe
  ack_needs_stb: assert property (
    @(posedge clk) disable iff (reset_i) ack_i |-> stb_i
  ) else $error("ack_o high while stb_i is low");

  // Controller leaves reset with no request
  quiet_after_reset: assert property (
    @(posedge clk) reset_i |=> !intr_i
  ) else $error("intr_o high in the cycle after reset");

  legal_state: assert property (
    @(posedge clk) disable iff (reset_i)
      state_i inside {IRQ_IDLE, IRQ_REQUEST, IRQ_SERVE}
  ) else $error("Interrupt controller FSM in an illegal state");

endmodule

//--- test/io_system_tb.sv
// I/O subsystem testbench
`timescale 1ns/1ns
`include "pc_io_defs.svh"

module io_system_tb
  import pc_io_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 2000;
  localparam int STALL_LIMIT    = 16;
  localparam int RAM_DEPTH      = 2 ** `RAM_ADDR_BITS;

  logic       clk;
  logic       reset_i;
  addr_t      adr;
  word_t      wdata;
  logic       we;
  logic       tga;
  sel_t       sel;
  logic       stb;
  logic       cyc;
  logic       inta;
  word_t      sw;
  logic [7:1] irq;
  word_t      rdata;
  logic       ack;
  logic       intr;
  word_t      led;
  int         errors;
  int         checks;
  int         tests;
  int         cycles = 0;

  io_system io_system_inst (
    .clk     (clk),
    .reset_i (reset_i),
    .adr_i   (adr),
    .dat_i   (wdata),
    .we_i    (we),
    .tga_i   (tga),
    .sel_i   (sel),
    .stb_i   (stb),
    .cyc_i   (cyc),
    .inta_i  (inta),
    .sw_i    (sw),
    .irq_i   (irq),
    .dat_o   (rdata),
    .ack_o   (ack),
    .intr_o  (intr),
    .led_o   (led)
  );

  bind io_system io_system_properties props_inst (
    .clk     (clk),
    .reset_i (reset_i),
    .stb_i   (stb_i),
    .ack_i   (ack_o),
    .intr_i  (intr_o),
    .state_i (irq_controller_inst.state)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles before the tests were done", cycles);
      $display("Something failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input word_t got, input word_t expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, expected);
    end
  endtask

  function automatic addr_t port_addr(input word_t port);
    return addr_t'(port >> 1);
  endfunction

  // One master cycle, held until the acknowledge is seen
  task automatic bus_cycle(input logic io, input logic write, input logic int_ack,
                           input addr_t a, input word_t d, output word_t q);
    int waited;
    waited = 0;
    q = '0;
    @(posedge clk);
    #5;
    adr   = a;
    wdata = d;
    we    = write;
    tga   = io;
    sel   = 2'b11;
    inta  = int_ack;
    stb   = 1'b1;
    cyc   = 1'b1;
    @(negedge clk);
    while (!ack && waited < STALL_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    if (ack) begin
      q = rdata;
      // I/O answers in the strobe cycle, the RAM one cycle later
      check_value("ack_o wait states", word_t'(waited), io ? 16'd0 : 16'd1);
    end else begin
      errors++;
      $display("Bus cycle at %0t ns got no acknowledge", $time);
    end
    @(posedge clk);
    #5;
    stb  = 1'b0;
    cyc  = 1'b0;
    we   = 1'b0;
    inta = 1'b0;
  endtask

  task automatic wait_intr(input int limit);
    int waited;
    waited = 1;
    @(negedge clk);
    while (!intr && waited < limit) begin
      waited++;
      @(negedge clk);
    end
    if (!intr) begin
      errors++;
      $display("No interrupt request within %0d cycles at %0t ns", limit, $time);
    end
  endtask

  // intr_o must stay low for n cycles
  task automatic expect_quiet(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      check_value("intr_o", word_t'(intr), 16'h0000);
      if (intr) begin
        break;
      end
    end
  endtask

  task automatic pulse_lines(input logic [7:1] lines);
    @(posedge clk);
    #5;
    irq = lines;
    @(posedge clk);
    #5;
    irq = '0;
  endtask

  task automatic report_test(input string name, input int start);
    tests++;
    $display("%s test finished with %0d errors", name, errors - start);
  endtask

  task automatic ram_checks();
    int    start;
    addr_t a [8];
    word_t d [8];
    word_t model [int];
    word_t got;
    addr_t base;
    word_t first;
    start = errors;
    for (int i = 0; i < 8; i++) begin
      a[i] = addr_t'($urandom);
      d[i] = word_t'($urandom);
      model[int'(a[i]) % RAM_DEPTH] = d[i];
      bus_cycle(1'b0, 1'b1, 1'b0, a[i], d[i], got);
    end
    for (int i = 0; i < 8; i++) begin
      bus_cycle(1'b0, 1'b0, 1'b0, a[i], '0, got);
      check_value("dat_o", got, model[int'(a[i]) % RAM_DEPTH]);
    end
    // Same word seen one RAM depth higher
    base  = addr_t'($urandom);
    first = word_t'($urandom);
    bus_cycle(1'b0, 1'b1, 1'b0, base, first, got);
    bus_cycle(1'b0, 1'b0, 1'b0, base + addr_t'(RAM_DEPTH), '0, got);
    check_value("dat_o", got, first);
    bus_cycle(1'b0, 1'b1, 1'b0, base + addr_t'(RAM_DEPTH), ~first, got);
    bus_cycle(1'b0, 1'b0, 1'b0, base, '0, got);
    check_value("dat_o", got, ~first);
    report_test("RAM", start);
  endtask

  task automatic port_checks();
    int    start;
    word_t value;
    word_t got;
    start = errors;
    value = word_t'($urandom);
    bus_cycle(1'b1, 1'b1, 1'b0, port_addr(`IO_PORT_LED), value, got);
    check_value("led_o", led, value);
    sw = word_t'($urandom);
    bus_cycle(1'b1, 1'b0, 1'b0, port_addr(`IO_PORT_SW), '0, got);
    check_value("dat_o", got, sw);
    bus_cycle(1'b1, 1'b0, 1'b0, port_addr(16'h0300), '0, got);
    check_value("dat_o", got, 16'hFFFF);
    value = word_t'($urandom);
    bus_cycle(1'b1, 1'b1, 1'b0, port_addr(`IO_PORT_IRQ_MASK), value, got);
    bus_cycle(1'b1, 1'b0, 1'b0, port_addr(`IO_PORT_IRQ_MASK), '0, got);
    check_value("dat_o", got, value);
    bus_cycle(1'b1, 1'b1, 1'b0, port_addr(`IO_PORT_IRQ_MASK), 16'h0000, got);
    report_test("I/O port", start);
  endtask

  task automatic timer_checks();
    int    start;
    int    reload;
    word_t got;
    start  = errors;
    reload = 12 + int'($urandom % 8);
    bus_cycle(1'b1, 1'b1, 1'b0, port_addr(`IO_PORT_TIMER), word_t'(reload), got);
    wait_intr(reload + 3);
    bus_cycle(1'b1, 1'b0, 1'b1, '0, '0, got);
    check_value("dat_o", got, 16'h0008);
    // Reload register reads back while the timer runs
    bus_cycle(1'b1, 1'b0, 1'b0, port_addr(`IO_PORT_TIMER), '0, got);
    check_value("dat_o", got, word_t'(reload));
    bus_cycle(1'b1, 1'b1, 1'b0, port_addr(`IO_PORT_TIMER), 16'h0000, got);
    expect_quiet(3 * reload);
    report_test("Timer", start);
  endtask

  task automatic priority_checks();
    int         start;
    logic [7:1] lines;
    word_t      got;
    start    = errors;
    lines    = '0;
    lines[5] = 1'b1;
    lines[3] = 1'b1;
    pulse_lines(lines);
    wait_intr(8);
    bus_cycle(1'b1, 1'b0, 1'b1, '0, '0, got);
    check_value("dat_o", got, 16'h0008 | 16'd3);
    wait_intr(8);
    bus_cycle(1'b1, 1'b0, 1'b1, '0, '0, got);
    check_value("dat_o", got, 16'h0008 | 16'd5);
    expect_quiet(4);
    report_test("Priority", start);
  endtask

  task automatic masking_checks();
    int         start;
    logic [7:1] lines;
    word_t      got;
    start    = errors;
    lines    = '0;
    lines[2] = 1'b1;
    bus_cycle(1'b1, 1'b1, 1'b0, port_addr(`IO_PORT_IRQ_MASK), 16'h0004, got);
    pulse_lines(lines);
    expect_quiet(6);
    bus_cycle(1'b1, 1'b1, 1'b0, port_addr(`IO_PORT_IRQ_MASK), 16'h0000, got);
    wait_intr(4);
    bus_cycle(1'b1, 1'b0, 1'b1, '0, '0, got);
    check_value("dat_o", got, 16'h0008 | 16'd2);
    expect_quiet(4);
    report_test("Masking", start);
  endtask

  initial begin
    void'($urandom(32'hb4184997));
    errors  = 0;
    checks  = 0;
    tests   = 0;
    reset_i = 1'b1;
    adr     = '0;
    wdata   = '0;
    we      = 1'b0;
    tga     = 1'b0;
    sel     = 2'b00;
    stb     = 1'b0;
    cyc     = 1'b0;
    inta    = 1'b0;
    sw      = '0;
    irq     = '0;
    repeat (3) @(posedge clk);
    #5;
    reset_i = 1'b0;
    ram_checks();
    port_checks();
    timer_checks();
    priority_checks();
    masking_checks();
    $display("%0d tests run, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+hdl
hdl/pc_io_pkg.sv
hdl/io_decoder.sv
hdl/word_ram.sv
hdl/interval_timer.sv
hdl/irq_controller.sv
hdl/io_system.sv
test/io_system_properties.sv
test/io_system_tb.sv

//--- Makefile
TOP = io_system_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -f sim.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

.PHONY: sim clean
